// ==== mmu_top.f ====
+incdir+src
src/mmu_pkg.sv
src/mmu_tlb.sv
src/mmu_ptw.sv
src/mmu_pte_port.sv
src/mmu_top.sv
verification/mmu_checker.sv
verification/mmu_tb.sv

// ==== src/mmu_params.svh ====
//////////////////////////////
// Sv39 MMU sizes
//////////////////////////////
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Virtual and physical page numbers
`define MMU_VPN_WIDTH 27
`define MMU_PPN_WIDTH 44

// Page-table entry and page layout
`define MMU_PTE_WIDTH 64
`define MMU_PAGE_OFFSET_WIDTH 12

// Walk depth and index per level
`define MMU_PT_LEVELS 3
`define MMU_VPN_SLICE_WIDTH 9

// Power of two of at least 2
`define MMU_TLB_ENTRIES 8

`endif

// ==== src/mmu_pkg.sv ====
//////////////////////////////
// MMU shared types
//////////////////////////////
`include "mmu_params.svh"

package mmu_pkg;

  typedef logic [`MMU_VPN_WIDTH-1:0] vpn_t;
  typedef logic [`MMU_PPN_WIDTH-1:0] ppn_t;
  typedef logic [`MMU_PTE_WIDTH-1:0] pte_data_t;
  typedef logic [1:0] level_t;

  typedef struct packed {
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
  } perm_t;

  typedef struct packed {
    ppn_t  ppn;
    perm_t perm;
  } tlb_entry_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } xlate_req_t;

  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
    ppn_t  ppn;
    perm_t perm;
  } xlate_resp_t;

  typedef struct packed {
    logic                              valid;
    ppn_t                              ppn;
    logic [`MMU_PAGE_OFFSET_WIDTH-1:0] offset; // Byte offset in the table page
  } pte_req_t;

  typedef struct packed {
    logic      valid;
    logic      miss;
    pte_data_t data;
  } pte_resp_t;

  typedef enum logic [1:0] {PTW_IDLE, PTW_SEND, PTW_WAIT, PTW_FILL} ptw_state_e;
  typedef enum logic {PORT_EMPTY, PORT_ISSUED} port_state_e;

endpackage

// ==== src/mmu_pte_port.sv ====
//////////////////////////////
// Page-table memory port
//////////////////////////////
`include "mmu_params.svh"

module mmu_pte_port (
  input  logic               clk_i,
  input  logic               reset_i,
  input  mmu_pkg::pte_req_t  walk_req_i,
  output logic               walk_ready_o,
  output mmu_pkg::pte_resp_t walk_resp_o,
  output mmu_pkg::pte_req_t  pte_req_o,
  input  logic               mem_ready_i,
  input  mmu_pkg::pte_resp_t pte_resp_i
);

  mmu_pkg::port_state_e              state_r;
  logic                              req_v_r;
  mmu_pkg::ppn_t                     req_ppn_r;
  logic [`MMU_PAGE_OFFSET_WIDTH-1:0] req_offset_r;
  logic                              resp_v_r;
  logic                              resp_miss_r;
  mmu_pkg::pte_data_t                resp_data_r;

  logic capture;
  logic xfer;
  logic take_resp;

  assign walk_ready_o = (state_r == mmu_pkg::PORT_EMPTY) & ~req_v_r;
  assign capture      = walk_ready_o & walk_req_i.valid;
  assign xfer         = req_v_r & mem_ready_i;
  // A same-cycle answer is taken as well
  assign take_resp    = pte_resp_i.valid & ((state_r == mmu_pkg::PORT_ISSUED) | xfer);

  always_comb begin
    pte_req_o.valid    = req_v_r;
    pte_req_o.ppn      = req_ppn_r;
    pte_req_o.offset   = req_offset_r;
    walk_resp_o.valid  = resp_v_r;
    walk_resp_o.miss   = resp_miss_r;
    walk_resp_o.data   = resp_data_r;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= mmu_pkg::PORT_EMPTY;
      req_v_r  <= 1'b0;
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= take_resp;
      if (capture) begin
        req_v_r <= 1'b1;
      end else if (xfer) begin
        req_v_r <= 1'b0;
      end
      if (xfer && !pte_resp_i.valid) begin
        state_r <= mmu_pkg::PORT_ISSUED;
      end else if (take_resp) begin
        state_r <= mmu_pkg::PORT_EMPTY;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_ppn_r    <= walk_req_i.ppn;
      req_offset_r <= walk_req_i.offset;
    end
    if (take_resp) begin
      resp_miss_r <= pte_resp_i.miss;
      resp_data_r <= pte_resp_i.data;
    end
  end

endmodule

// ==== src/mmu_ptw.sv ====
//////////////////////////////
// Sv39 page-table walker
//////////////////////////////
`include "mmu_params.svh"

module mmu_ptw (
  input  logic                clk_i,
  input  logic                reset_i,
  input  mmu_pkg::ppn_t       root_ppn_i,
  input  logic                miss_v_i,
  input  mmu_pkg::vpn_t       miss_vpn_i,
  output logic                fill_v_o,
  output mmu_pkg::vpn_t       fill_vpn_o,
  output mmu_pkg::tlb_entry_t fill_entry_o,
  output mmu_pkg::pte_req_t   walk_req_o,
  input  logic                walk_ready_i,
  input  mmu_pkg::pte_resp_t  walk_resp_i
);

  localparam int SLICE        = `MMU_VPN_SLICE_WIDTH;
  localparam int LG_PTE_BYTES = `MMU_PAGE_OFFSET_WIDTH - `MMU_VPN_SLICE_WIDTH;

  mmu_pkg::ptw_state_e state_r, state_n;
  mmu_pkg::level_t     level_r;
  mmu_pkg::vpn_t       vpn_r;
  mmu_pkg::ppn_t       ppn_r;
  mmu_pkg::perm_t      perm_r;

  mmu_pkg::pte_data_t pte;
  mmu_pkg::ppn_t      pte_ppn;
  mmu_pkg::perm_t     pte_perm;
  logic               pte_leaf;
  logic               start;
  logic               resp_v;
  logic [SLICE-1:0]   vpn_slice;
  mmu_pkg::ppn_t      fill_ppn;

  // Sv39 PTE fields
  assign pte      = walk_resp_i.data;
  assign pte_ppn  = pte[10 +: `MMU_PPN_WIDTH];
  assign pte_perm = '{g: pte[5], u: pte[4], x: pte[3], w: pte[2], r: pte[1]};
  assign pte_leaf = pte_perm.x | pte_perm.w | pte_perm.r;

  assign start     = (state_r == mmu_pkg::PTW_IDLE) & miss_v_i;
  assign resp_v    = (state_r == mmu_pkg::PTW_WAIT) & walk_resp_i.valid & ~walk_resp_i.miss;
  assign vpn_slice = vpn_r[level_r*SLICE +: SLICE];

  always_comb begin
    walk_req_o.valid  = (state_r == mmu_pkg::PTW_SEND);
    walk_req_o.ppn    = ppn_r;
    walk_req_o.offset = {vpn_slice, LG_PTE_BYTES'(0)}; // Index scaled by 8 bytes
  end

  // Superpages keep the low VPN slices
  always_comb begin
    fill_ppn = ppn_r;
    for (int i = 0; i < `MMU_PT_LEVELS-1; i++) begin
      if (level_r > i) begin
        fill_ppn[i*SLICE +: SLICE] = vpn_r[i*SLICE +: SLICE];
      end
    end
  end

  assign fill_v_o          = (state_r == mmu_pkg::PTW_FILL);
  assign fill_vpn_o        = vpn_r;
  assign fill_entry_o.ppn  = fill_ppn;
  assign fill_entry_o.perm = perm_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      mmu_pkg::PTW_IDLE: begin
        if (miss_v_i) state_n = mmu_pkg::PTW_SEND;
      end
      mmu_pkg::PTW_SEND: begin
        if (walk_ready_i) state_n = mmu_pkg::PTW_WAIT;
      end
      mmu_pkg::PTW_WAIT: begin
        if (walk_resp_i.valid) begin
          if (walk_resp_i.miss) begin
            state_n = mmu_pkg::PTW_SEND; // Resend the same read
          end else if (pte_leaf || level_r == '0) begin
            state_n = mmu_pkg::PTW_FILL; // Level 0 always ends the walk
          end else begin
            state_n = mmu_pkg::PTW_SEND;
          end
        end
      end
      default: state_n = mmu_pkg::PTW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mmu_pkg::PTW_IDLE;
      level_r <= '0;
    end else begin
      state_r <= state_n;
      if (start) begin
        level_r <= mmu_pkg::level_t'(`MMU_PT_LEVELS - 1);
      end else if (resp_v && !pte_leaf && level_r != '0) begin
        level_r <= level_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      vpn_r <= miss_vpn_i;
      ppn_r <= root_ppn_i;
    end else if (resp_v) begin
      ppn_r  <= pte_ppn; // Next table or leaf page
      perm_r <= pte_perm;
    end
  end

endmodule

// ==== src/mmu_tlb.sv ====
//////////////////////////////
// Fully associative TLB
//////////////////////////////
`include "mmu_params.svh"

module mmu_tlb (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mmu_pkg::xlate_req_t  xlate_req_i,
  output logic                 xlate_ready_o,
  output mmu_pkg::xlate_resp_t xlate_resp_o,
  output logic                 miss_v_o,
  output mmu_pkg::vpn_t        miss_vpn_o,
  input  logic                 fill_v_i,
  input  mmu_pkg::vpn_t        fill_vpn_i,
  input  mmu_pkg::tlb_entry_t  fill_entry_i
);

  localparam int IDX_WIDTH = $clog2(`MMU_TLB_ENTRIES);

  logic [`MMU_TLB_ENTRIES-1:0] valid_r;
  mmu_pkg::vpn_t               tag_r   [`MMU_TLB_ENTRIES];
  mmu_pkg::tlb_entry_t         entry_r [`MMU_TLB_ENTRIES];
  logic [IDX_WIDTH-1:0]        victim_r;

  logic                busy_r;
  logic                miss_v_r;
  mmu_pkg::vpn_t       req_vpn_r;
  logic                resp_v_r;
  mmu_pkg::vpn_t       resp_vpn_r;
  mmu_pkg::tlb_entry_t resp_entry_r;

  logic                accept;
  logic                hit;
  mmu_pkg::tlb_entry_t hit_entry;

  assign xlate_ready_o = ~busy_r;
  assign accept        = xlate_req_i.valid & ~busy_r;
  assign miss_v_o      = miss_v_r;
  assign miss_vpn_o    = req_vpn_r; // Missing request stays here until the fill

  // Tags are unique since fills only follow misses
  always_comb begin
    hit       = 1'b0;
    hit_entry = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (valid_r[i] && tag_r[i] == xlate_req_i.vpn) begin
        hit       = 1'b1;
        hit_entry = entry_r[i];
      end
    end
  end

  always_comb begin
    xlate_resp_o.valid = resp_v_r;
    xlate_resp_o.vpn   = resp_vpn_r;
    xlate_resp_o.ppn   = resp_entry_r.ppn;
    xlate_resp_o.perm  = resp_entry_r.perm;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
      busy_r   <= 1'b0;
      miss_v_r <= 1'b0;
      resp_v_r <= 1'b0;
    end else begin
      miss_v_r <= accept & ~hit; // One-cycle pulse to the walker
      resp_v_r <= (accept & hit) | fill_v_i;
      if (accept && !hit) begin
        busy_r <= 1'b1;
      end else if (fill_v_i) begin
        busy_r <= 1'b0;
      end
      if (fill_v_i) begin
        valid_r[victim_r] <= 1'b1;
        victim_r          <= victim_r + 1'b1; // Round-robin replacement
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_vpn_r <= xlate_req_i.vpn;
    end
    if (fill_v_i) begin
      tag_r[victim_r]   <= fill_vpn_i;
      entry_r[victim_r] <= fill_entry_i;
      resp_vpn_r        <= req_vpn_r;
      resp_entry_r      <= fill_entry_i; // Answer the held request from the fill
    end else if (accept) begin
      resp_vpn_r   <= xlate_req_i.vpn;
      resp_entry_r <= hit_entry;
    end
  end

endmodule

// ==== src/mmu_top.sv ====
//////////////////////////////
// Sv39 MMU top
//////////////////////////////
module mmu_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mmu_pkg::ppn_t        root_ppn_i,
  input  mmu_pkg::xlate_req_t  xlate_req_i,
  output logic                 xlate_ready_o,
  output mmu_pkg::xlate_resp_t xlate_resp_o,
  output mmu_pkg::pte_req_t    pte_req_o,
  input  logic                 mem_ready_i,
  input  mmu_pkg::pte_resp_t   pte_resp_i
);

  logic                miss_v;
  mmu_pkg::vpn_t       miss_vpn;
  logic                fill_v;
  mmu_pkg::vpn_t       fill_vpn;
  mmu_pkg::tlb_entry_t fill_entry;
  mmu_pkg::pte_req_t   walk_req;
  logic                walk_ready;
  mmu_pkg::pte_resp_t  walk_resp;

  mmu_tlb i_mmu_tlb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .xlate_req_i   (xlate_req_i),
    .xlate_ready_o (xlate_ready_o),
    .xlate_resp_o  (xlate_resp_o),
    .miss_v_o      (miss_v),
    .miss_vpn_o    (miss_vpn),
    .fill_v_i      (fill_v),
    .fill_vpn_i    (fill_vpn),
    .fill_entry_i  (fill_entry)
  );

  mmu_ptw i_mmu_ptw (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .root_ppn_i   (root_ppn_i),
    .miss_v_i     (miss_v),
    .miss_vpn_i   (miss_vpn),
    .fill_v_o     (fill_v),
    .fill_vpn_o   (fill_vpn),
    .fill_entry_o (fill_entry),
    .walk_req_o   (walk_req),
    .walk_ready_i (walk_ready),
    .walk_resp_i  (walk_resp)
  );

  mmu_pte_port i_mmu_pte_port (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .walk_req_i   (walk_req),
    .walk_ready_o (walk_ready),
    .walk_resp_o  (walk_resp),
    .pte_req_o    (pte_req_o),
    .mem_ready_i  (mem_ready_i),
    .pte_resp_i   (pte_resp_i)
  );

endmodule

// ==== verification/mmu_checker.sv ====
//////////////////////////////
// MMU response checker
//////////////////////////////
`include "mmu_params.svh"

module mmu_checker (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mmu_pkg::ppn_t        root_ppn_i,
  input  mmu_pkg::xlate_req_t  xlate_req_i,
  input  logic                 xlate_ready_i,
  input  mmu_pkg::xlate_resp_t xlate_resp_i,
  input  mmu_pkg::pte_req_t    pte_req_i,
  input  logic                 mem_ready_i,
  input  mmu_pkg::pte_resp_t   pte_resp_i,
  output int                   errors_o,
  output int                   resp_count_o
);

  localparam int ADDR_W = `MMU_PPN_WIDTH + `MMU_PAGE_OFFSET_WIDTH;
  localparam int SLICE  = `MMU_VPN_SLICE_WIDTH;

  typedef struct {
    mmu_pkg::vpn_t       vpn;
    mmu_pkg::tlb_entry_t ent;
    logic                hit;
    int                  cyc;
  } expect_t;

  expect_t                     pending[$]; // Accepted requests in order
  logic [ADDR_W-1:0]           walk_addr[$];
  mmu_pkg::vpn_t               tlb_vpn [`MMU_TLB_ENTRIES];
  mmu_pkg::tlb_entry_t         tlb_ent [`MMU_TLB_ENTRIES];
  logic [`MMU_TLB_ENTRIES-1:0] tlb_valid;
  int                          victim;
  int                          errors = 0;
  int                          resp_count = 0;
  int                          cyc = 0;
  int                          reads;
  int                          miss_resps;
  int                          walk_len;
  logic                        walk_active;
  logic                        in_reset = 1'b0;
  mmu_pkg::pte_req_t           prev_req;
  logic                        prev_mem_ready;

  assign errors_o     = errors;
  assign resp_count_o = resp_count;

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("CHECK FAILED %s expected %h actual %h at cycle %0d", name, exp_val, act_val, cyc);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s at cycle %0d", msg, cyc);
    errors++;
  endtask

  // Sv39 walk over the testbench page table up to the first R/W/X entry
  function automatic mmu_pkg::tlb_entry_t ref_walk(input mmu_pkg::vpn_t vpn,
                                                   input mmu_pkg::ppn_t root);
    mmu_pkg::tlb_entry_t ent;
    mmu_pkg::pte_data_t  pte;
    logic [ADDR_W-1:0]   addr;
    ent.ppn  = root;
    ent.perm = '0;
    walk_addr.delete();
    for (int lvl = `MMU_PT_LEVELS-1; lvl >= 0; lvl--) begin
      addr = {ent.ppn, vpn[lvl*SLICE +: SLICE], 3'b000};
      walk_addr.push_back(addr);
      pte = mmu_tb.pt_mem.exists(addr) ? mmu_tb.pt_mem[addr] : '0;
      ent.ppn = pte[10 +: `MMU_PPN_WIDTH];
      if (pte[3:1] != 3'b000 || lvl == 0) begin
        ent.perm = '{g: pte[5], u: pte[4], x: pte[3], w: pte[2], r: pte[1]};
        for (int i = 0; i < lvl; i++) begin
          ent.ppn[i*SLICE +: SLICE] = vpn[i*SLICE +: SLICE]; // Superpage merge
        end
        break;
      end
    end
    return ent;
  endfunction

  always @(posedge clk_i) begin
    expect_t e;
    if (reset_i) begin
      pending.delete();
      walk_addr.delete();
      tlb_valid   = '0;
      victim      = 0;
      walk_active = 1'b0;
      in_reset    = 1'b1;
    end else begin
      if (in_reset) begin
        check_value("reset_state", 3'b100, {xlate_ready_i, xlate_resp_i.valid, pte_req_i.valid});
        in_reset = 1'b0;
      end
      if (prev_req.valid && !prev_mem_ready) begin
        check_value("pte_req_hold", prev_req, pte_req_i); // Held under back-pressure
      end
      if (pte_req_i.valid && mem_ready_i) begin
        if (!walk_active || walk_addr.size() == 0) begin
          report_error("memory read issued with no walk pending");
        end else begin
          check_value("walk_addr", walk_addr[0], {pte_req_i.ppn, pte_req_i.offset});
        end
        reads++;
      end
      if (pte_resp_i.valid) begin
        if (pte_resp_i.miss) begin
          miss_resps++; // Same address is read again
        end else if (walk_addr.size() > 0) begin
          void'(walk_addr.pop_front());
        end
      end
      if (xlate_resp_i.valid) begin
        if (pending.size() == 0) begin
          report_error("translation response with no request pending");
        end else begin
          e = pending.pop_front();
          check_value("xlate_vpn", e.vpn, xlate_resp_i.vpn);
          check_value("xlate_ppn_perm", e.ent, {xlate_resp_i.ppn, xlate_resp_i.perm});
          if (e.hit) begin
            check_value("hit_latency", e.cyc + 1, cyc);
          end else begin
            check_value("walk_reads", walk_len + miss_resps, reads);
            walk_active = 1'b0;
          end
        end
        resp_count++;
      end
      check_value("xlate_ready", !walk_active, xlate_ready_i);
      if (xlate_req_i.valid && xlate_ready_i) begin
        e.vpn = xlate_req_i.vpn;
        e.hit = 1'b0;
        e.cyc = cyc;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
          if (tlb_valid[i] && tlb_vpn[i] == e.vpn) begin
            e.hit = 1'b1;
            e.ent = tlb_ent[i];
          end
        end
        if (!e.hit) begin
          e.ent       = ref_walk(e.vpn, root_ppn_i);
          walk_len    = walk_addr.size();
          reads       = 0;
          miss_resps  = 0;
          walk_active = 1'b1;
          tlb_vpn[victim]   = e.vpn;
          tlb_ent[victim]   = e.ent;
          tlb_valid[victim] = 1'b1;
          victim = (victim + 1) % `MMU_TLB_ENTRIES; // Round-robin copy of the TLB
        end
        pending.push_back(e);
      end
      cyc++;
    end
    prev_req       = pte_req_i;
    prev_mem_ready = mem_ready_i;
  end

endmodule

// ==== verification/mmu_tb.sv ====
//////////////////////////////
// Sv39 MMU testbench
//////////////////////////////
`include "mmu_params.svh"

module mmu_tb;

  localparam int N_REQ   = 200;
  localparam int N_VPNS  = 12;
  localparam int TIMEOUT = 40 * N_REQ + 200;
  localparam int ADDR_W  = `MMU_PPN_WIDTH + `MMU_PAGE_OFFSET_WIDTH;
  localparam int SLICE   = `MMU_VPN_SLICE_WIDTH;

  logic                 clk_i;
  logic                 reset_i     = 1'b1;
  mmu_pkg::ppn_t        root_ppn_i  = '0;
  mmu_pkg::xlate_req_t  xlate_req_i = '0;
  logic                 xlate_ready_o;
  mmu_pkg::xlate_resp_t xlate_resp_o;
  mmu_pkg::pte_req_t    pte_req_o;
  logic                 mem_ready_i = 1'b0;
  mmu_pkg::pte_resp_t   pte_resp_i  = '0;

  mmu_pkg::pte_data_t pt_mem [logic [ADDR_W-1:0]]; // Sparse page table
  mmu_pkg::vpn_t      vpn_pool [N_VPNS];
  logic [31:0]        lfsr = 32'hf73cf4fb;
  int                 accepted = 0;
  int                 cycles = 0;
  int                 errors;
  int                 resp_count;
  logic               rd_pend = 1'b0;
  int                 rd_delay;
  logic               rd_miss;
  mmu_pkg::pte_data_t rd_data;

  mmu_top i_mmu_top (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .root_ppn_i    (root_ppn_i),
    .xlate_req_i   (xlate_req_i),
    .xlate_ready_o (xlate_ready_o),
    .xlate_resp_o  (xlate_resp_o),
    .pte_req_o     (pte_req_o),
    .mem_ready_i   (mem_ready_i),
    .pte_resp_i    (pte_resp_i)
  );

  mmu_checker i_mmu_checker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .root_ppn_i    (root_ppn_i),
    .xlate_req_i   (xlate_req_i),
    .xlate_ready_i (xlate_ready_o),
    .xlate_resp_i  (xlate_resp_o),
    .pte_req_i     (pte_req_o),
    .mem_ready_i   (mem_ready_i),
    .pte_resp_i    (pte_resp_i),
    .errors_o      (errors),
    .resp_count_o  (resp_count)
  );

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Few upper slices so tables are shared between VPNs
  task automatic build_table();
    mmu_pkg::ppn_t      ppn;
    mmu_pkg::ppn_t      next_table;
    mmu_pkg::pte_data_t pte;
    logic [ADDR_W-1:0]  addr;
    root_ppn_i = mmu_pkg::ppn_t'(take_bits(20));
    next_table = root_ppn_i + 1'b1;
    for (int v = 0; v < N_VPNS; v++) begin
      vpn_pool[v] = {SLICE'(take_bits(1)), SLICE'(take_bits(2)), SLICE'(take_bits(9))};
      ppn = root_ppn_i;
      for (int lvl = `MMU_PT_LEVELS-1; lvl >= 0; lvl--) begin
        addr = {ppn, vpn_pool[v][lvl*SLICE +: SLICE], 3'b000};
        if (!pt_mem.exists(addr)) begin
          pte    = '0;
          pte[0] = 1'b1;
          if (lvl == 0 || take_bits(2) == 64'd0) begin
            pte[10 +: `MMU_PPN_WIDTH] = mmu_pkg::ppn_t'(take_bits(44));
            pte[5:1] = 5'(take_bits(5));
            if (pte[3:1] == 3'b000) begin
              pte[1] = 1'b1; // Leaf needs one of R, W, X
            end
          end else begin
            pte[10 +: `MMU_PPN_WIDTH] = next_table;
            next_table = next_table + 1'b1;
          end
          pt_mem[addr] = pte;
        end
        pte = pt_mem[addr];
        ppn = pte[10 +: `MMU_PPN_WIDTH];
        if (pte[3:1] != 3'b000) begin
          break;
        end
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    logic [ADDR_W-1:0] addr;
    if (!reset_i) begin
      if (xlate_req_i.valid && xlate_ready_o) begin
        accepted++;
      end
      if (!xlate_req_i.valid || xlate_ready_o) begin
        xlate_req_i.valid <= (accepted < N_REQ) && (take_bits(2) != 64'd0);
        xlate_req_i.vpn   <= vpn_pool[take_bits(4) % N_VPNS];
      end
      mem_ready_i <= (take_bits(2) != 64'd0);
      pte_resp_i  <= '0;
      if (rd_pend) begin
        if (rd_delay == 0) begin
          pte_resp_i <= '{valid: 1'b1, miss: rd_miss, data: rd_data};
          rd_pend = 1'b0;
        end else begin
          rd_delay--;
        end
      end
      if (pte_req_o.valid && mem_ready_i) begin
        addr     = {pte_req_o.ppn, pte_req_o.offset};
        rd_pend  = 1'b1;
        rd_delay = int'(take_bits(2));
        rd_miss  = (take_bits(3) == 64'd0); // About one read in eight
        rd_data  = pt_mem.exists(addr) ? pt_mem[addr] : '0;
      end
    end
  end

  initial begin
    build_table();
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    while (resp_count < N_REQ && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (resp_count < N_REQ) begin
      $display("Timeout: %0d of %0d translations answered after %0d cycles",
               resp_count, N_REQ, cycles);
    end
    repeat (4) @(negedge clk_i);
    $display("Errors: %0d check failures, %0d of %0d responses", errors, resp_count, N_REQ);
    if (errors == 0 && resp_count == N_REQ) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
